// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = trace_capture_tb
FILELIST  = trace_capture_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== capture_ctrl.sv ====
`default_nettype none

module capture_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               arm,            // one-cycle pulse
  input  logic               trigger,        // level
  input  logic               sample_valid,
  input  trace_pkg::sample_t sample,
  input  trace_pkg::count_t  sample_count,
  input  logic               fifo_full,
  output logic               fifo_wen,
  output trace_pkg::sample_t fifo_wdata,
  output logic               busy,
  output logic               done,
  output logic               truncated
);

  import trace_pkg::*;

  cap_state_t state;
  count_t     remaining;   // writes still owed in this capture
  logic       offered;     // valid sample while capturing
  logic       dropped;     // offered but fifo has no room
  logic       last_write;

  assign offered    = (state == CAPTURING) && sample_valid;
  assign fifo_wen   = offered && !fifo_full;   // written on this same edge
  assign dropped    = offered && fifo_full;
  assign fifo_wdata = sample;
  assign last_write = (remaining == count_t'(1));

  assign busy = (state != IDLE);   // high from the arm edge until the end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      remaining <= '0;
      done      <= 1'b0;
      truncated <= 1'b0;
    end else begin
      done <= 1'b0;   // pulse by default

      case (state)
        IDLE: begin
          if (arm) begin
            state     <= ARMED;
            truncated <= 1'b0;   // sticky flag lives until the next arm
          end
        end

        ARMED: begin
          // sample present alongside the trigger is skipped
          if (trigger) begin
            remaining <= sample_count;
            if (sample_count == '0) begin
              state <= IDLE;     // nothing requested, finish at once
              done  <= 1'b1;
            end else begin
              state <= CAPTURING;
            end
          end
        end

        CAPTURING: begin
          if (dropped) begin
            // no stall on full, end the capture and flag it
            truncated <= 1'b1;
            done      <= 1'b1;
            state     <= IDLE;
          end else if (fifo_wen) begin
            remaining <= remaining - 1'b1;
            if (last_write) begin
              done  <= 1'b1;
              state <= IDLE;
            end
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== fifo_sync.sv ====
`default_nettype none

module fifo_sync #(
  parameter int pDATA_WIDTH  = 8,
  parameter int pDEPTH       = 32,   // power of two, 32 up to 65536
  parameter bit pFALLTHROUGH = 0     // first word fall through
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            full_threshold_value,
  input  logic                   wen,
  input  logic [pDATA_WIDTH-1:0] wdata,
  output logic                   full,
  output logic                   overflow,
  output logic                   full_threshold,
  input  logic                   ren,
  output logic [pDATA_WIDTH-1:0] rdata,
  output logic                   empty,
  output logic                   almost_empty,
  output logic                   underflow
);

  localparam int pADDR_WIDTH = $clog2(pDEPTH);

  logic [pADDR_WIDTH:0]   wptr;           // msb is the wrap bit
  logic [pADDR_WIDTH:0]   rptr;
  logic [pADDR_WIDTH:0]   rptr_inc;
  logic [pADDR_WIDTH-1:0] waddr;
  logic [pADDR_WIDTH-1:0] raddr;
  logic [pADDR_WIDTH-1:0] thresh_trim;
  logic                   do_write;
  logic                   do_read;
  logic [pDATA_WIDTH-1:0] mem [pDEPTH];   // flop storage
  logic [pDATA_WIDTH-1:0] head_word;

  // almost-full compare, two extra msbs keep the sum from wrapping
  logic [pADDR_WIDTH+1:0] rptr_plus_th;
  logic [pADDR_WIDTH+1:0] wptr_ext;
  logic                   w_wrapped;

  assign waddr       = wptr[pADDR_WIDTH-1:0];
  assign raddr       = rptr[pADDR_WIDTH-1:0];
  assign rptr_inc    = rptr + 1'b1;
  assign thresh_trim = full_threshold_value[pADDR_WIDTH-1:0];   // upper bits ignored

  // accepted operations only
  assign do_write = wen && !full;
  assign do_read  = ren && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (do_write)
        wptr <= wptr + 1'b1;
      if (do_read)
        rptr <= rptr_inc;
    end
  end

  // rejected requests give a one-cycle pulse a cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      overflow  <= wen && full;
      underflow <= ren && empty;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write)
      mem[waddr] <= wdata;
  end

  assign head_word = mem[raddr];   // async read of the oldest entry

  generate
    if (pFALLTHROUGH) begin : g_fwft
      // head visible before the pop
      assign rdata = head_word;
    end else begin : g_reg_read
      logic [pDATA_WIDTH-1:0] rdata_reg;

      // word appears the cycle after ren
      always_ff @(posedge clk) begin
        if (do_read)
          rdata_reg <= head_word;
      end

      assign rdata = rdata_reg;
    end
  endgenerate

  // status straight off the pointers
  assign empty        = (wptr == rptr);
  assign almost_empty = (wptr == rptr_inc) || empty;   // zero or one entry
  assign full         = (wptr[pADDR_WIDTH] != rptr[pADDR_WIDTH]) &&
                        (waddr == raddr);

  // level >= threshold, written as rptr + threshold <= wptr
  // when wptr has wrapped past the top and rptr has not, lift wptr by one wrap
  assign w_wrapped    = !wptr[pADDR_WIDTH] && rptr[pADDR_WIDTH];
  assign rptr_plus_th = {1'b0, rptr} + {2'b00, thresh_trim};
  assign wptr_ext     = {w_wrapped, wptr};

  assign full_threshold = (rptr_plus_th <= wptr_ext);   // threshold 0 reads as always set

endmodule

`default_nettype wire

// ==== readout_port.sv ====
`default_nettype none

module readout_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req,          // host request
  input  logic               fifo_empty,
  input  trace_pkg::sample_t fifo_rdata,   // head word, fall-through fifo
  output logic               fifo_ren,
  output logic               ack,
  output trace_pkg::sample_t rd_data
);

  logic pop;   // handshake start, one per req

  // start only in the idle phase with data waiting
  // empty fifo keeps ack low so the host just waits
  assign pop      = req && !ack && !fifo_empty;
  assign fifo_ren = pop;   // single cycle since ack rises on this edge

  // ack rises with the pop, falls once the host lets go of req
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else if (pop) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  // held until the next rising ack
  always_ff @(posedge clk) begin
    if (pop)
      rd_data <= fifo_rdata;
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock #(
  parameter int pHALF_PERIOD = 2   // full period of 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(pHALF_PERIOD);
    clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== trace_capture_tb.sv ====
`default_nettype none

module trace_capture_tb;

  import trace_pkg::*;

  localparam int DEPTH    = 64;    // fifo depth handed to the top
  localparam int TIMEOUT  = 200;   // cycles allowed per wait
  localparam int AF_LEVEL = 40;    // almost-full threshold in words

  logic        clk;
  logic        rst_n;
  logic        arm;
  logic        trigger;
  logic        sample_valid;
  sample_t     sample;
  count_t      sample_count;
  logic [31:0] threshold;
  logic        req;
  logic        ack;
  sample_t     rd_data;
  logic        busy;
  logic        done;
  logic        truncated;
  logic        fifo_empty;
  logic        almost_full;

  logic [31:0] rng_state;
  sample_t     expected_q[$];   // words the fifo should hold in arrival order
  int          stored;          // fifo level by our own count of writes and reads
  string       test_name;

  tb_clock clock_gen (.clk(clk));

  trace_capture_top #(
    .pDEPTH       (DEPTH),
    .pFALLTHROUGH (1'b1)
  ) trace_capture_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .arm          (arm),
    .trigger      (trigger),
    .sample_valid (sample_valid),
    .sample       (sample),
    .sample_count (sample_count),
    .threshold    (threshold),
    .req          (req),
    .ack          (ack),
    .rd_data      (rd_data),
    .busy         (busy),
    .done         (done),
    .truncated    (truncated),
    .fifo_empty   (fifo_empty),
    .almost_full  (almost_full)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_sample(input string what, input sample_t exp, input sample_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAIL %s %s: expected %03h actual %03h",
                              test_name, what, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      stop_on_error($sformatf("FAIL %s %s: expected %0b actual %0b",
                              test_name, what, exp, act));
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp)
      stop_on_error($sformatf("FAIL %s %s: expected %0d actual %0d",
                              test_name, what, exp, act));
  endtask

  // all tasks below start and end just after a falling edge
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        stop_on_error($sformatf("ack never went to %0b within %0d cycles", level, TIMEOUT));
    end while (ack !== level);
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done !== 1'b1) begin   // usually already high right after the last write
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        stop_on_error("the done pulse never arrived");
    end
    check_flag("busy at done", 1'b0, busy);
    @(negedge clk);
    check_flag("done one cycle later", 1'b0, done);   // done is only a pulse
  endtask

  // one full four-phase handshake
  task automatic host_read(output sample_t word);
    req = 1'b1;        // ack is low here
    wait_ack(1'b1);
    word = rd_data;    // latched on the ack edge
    stored--;
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic read_expected(input string what);
    sample_t word;
    sample_t exp;
    host_read(word);
    if (expected_q.size() == 0) begin
      stop_on_error("a word was read back with no sample left to expect");
    end else begin
      exp = expected_q.pop_front();
      check_sample(what, exp, word);
    end
  endtask

  task automatic arm_capture(input count_t n);
    sample_count = n;
    arm          = 1'b1;
    @(negedge clk);
    arm = 1'b0;
    check_flag("busy after arm", 1'b1, busy);
  endtask

  // pre-trigger noise and the trigger cycle itself are never stored
  task automatic fire_trigger(input int pre);
    logic [31:0] r;
    repeat (pre) begin
      next_random(r);
      sample       = r[SAMPLE_W-1:0];
      sample_valid = r[20];
      @(negedge clk);
    end
    next_random(r);
    sample       = r[SAMPLE_W-1:0];
    sample_valid = 1'b1;   // sample beside the trigger is skipped
    trigger      = 1'b1;
    @(negedge clk);
    trigger      = 1'b0;
    sample_valid = 1'b0;
  endtask

  task automatic feed_samples(input int n, input int min_gap, input int max_gap,
                              input logic check_level);
    sample_t     s;
    logic [31:0] r;
    int          gap;
    for (int i = 0; i < n; i++) begin
      if (check_level)
        check_flag("almost_full while filling", stored >= AF_LEVEL, almost_full);
      check_flag("done during capture", 1'b0, done);
      next_random(r);
      s = r[SAMPLE_W-1:0];
      if (stored < DEPTH) begin   // a full fifo drops the sample
        expected_q.push_back(s);
        stored++;
      end
      sample_valid = 1'b1;
      sample       = s;
      @(negedge clk);
      sample_valid = 1'b0;
      if (i < n - 1) begin
        next_random(r);
        gap = min_gap + int'(r % 32'(max_gap - min_gap + 1));
        repeat (gap) @(negedge clk);   // idle cycles with valid low
      end
    end
  endtask

  task automatic drain_and_check(input string what, input int exp_words,
                                 input logic check_level);
    int got;
    got = 0;
    while (fifo_empty !== 1'b1) begin
      if (check_level)
        check_flag("almost_full while draining", stored >= AF_LEVEL, almost_full);
      read_expected(what);
      got++;
      if (got > 2 * DEPTH)
        stop_on_error("the fifo never went empty while draining");
    end
    check_count("words read back", count_t'(exp_words), count_t'(got));
    check_count("words still expected", count_t'(0), count_t'(expected_q.size()));
    check_flag("fifo_empty after drain", 1'b1, fifo_empty);
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    check_flag("ack", 1'b0, ack);
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    check_flag("truncated", 1'b0, truncated);
    check_flag("almost_full", 1'b0, almost_full);
    check_flag("fifo_empty", 1'b1, fifo_empty);
  endtask

  task automatic test_triggered_capture();
    test_name = "triggered_capture";
    arm_capture(count_t'(20));
    fire_trigger(6);
    feed_samples(20, 0, 2, 1'b0);   // gaps in sample_valid
    wait_done();
    check_flag("truncated", 1'b0, truncated);
    drain_and_check("word", 20, 1'b0);
  endtask

  task automatic test_overflow_truncation();
    test_name = "overflow_truncation";
    arm_capture(count_t'(100));
    fire_trigger(2);
    feed_samples(DEPTH + 1, 0, 0, 1'b0);   // one past full ends the capture
    wait_done();
    check_flag("truncated", 1'b1, truncated);
    drain_and_check("word", DEPTH, 1'b0);
    arm_capture(count_t'(1));
    check_flag("truncated after new arm", 1'b0, truncated);
    fire_trigger(0);
    feed_samples(1, 0, 0, 1'b0);
    wait_done();
    drain_and_check("word after rearm", 1, 1'b0);
  endtask

  task automatic test_almost_full();
    test_name = "almost_full";
    threshold = 32'(AF_LEVEL);
    arm_capture(count_t'(50));
    fire_trigger(3);
    feed_samples(50, 0, 1, 1'b1);   // level checked before every write
    wait_done();
    check_flag("almost_full at 50 words", 1'b1, almost_full);
    drain_and_check("word", 50, 1'b1);
    check_flag("almost_full when empty", 1'b0, almost_full);
  endtask

  task automatic test_streaming();
    test_name = "streaming";
    arm_capture(count_t'(200));
    fire_trigger(4);
    fork
      begin
        // at most one sample every two cycles to match the host's handshake rate
        feed_samples(200, 1, 3, 1'b0);
        wait_done();
        check_flag("truncated", 1'b0, truncated);
      end
      begin
        for (int i = 0; i < 200; i++)
          read_expected("word");
      end
    join
    check_count("words still expected", count_t'(0), count_t'(expected_q.size()));
    check_flag("fifo_empty", 1'b1, fifo_empty);
  endtask

  task automatic test_empty_stall();
    test_name = "empty_stall";
    check_flag("fifo_empty before req", 1'b1, fifo_empty);
    req = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check_flag("ack while empty", 1'b0, ack);   // host just waits
    end
    arm_capture(count_t'(1));
    fire_trigger(1);
    feed_samples(1, 0, 0, 1'b0);
    wait_done();
    read_expected("stalled word");   // req is still high so ack arrives now
    check_flag("fifo_empty after read", 1'b1, fifo_empty);
  endtask

  initial begin
    rng_state    = 32'h8245_baf8;
    stored       = 0;
    test_name    = "setup";
    rst_n        = 1'b0;
    arm          = 1'b0;
    trigger      = 1'b0;
    sample_valid = 1'b0;
    sample       = '0;
    sample_count = '0;
    threshold    = 32'(AF_LEVEL);   // zero would read as always almost full
    req          = 1'b0;

    repeat (16) @(posedge clk);   // sixteen rising edges in reset
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_triggered_capture();
    test_overflow_truncation();
    test_almost_full();
    test_streaming();
    test_empty_stall();

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== trace_capture_top.f ====
trace_pkg.sv
fifo_sync.sv
capture_ctrl.sv
readout_port.sv
trace_capture_top.sv
tb_clock.sv
trace_capture_tb.sv

// ==== trace_capture_top.sv ====
`default_nettype none

module trace_capture_top #(
  parameter int pDEPTH       = 64,
  parameter bit pFALLTHROUGH = 1   // readout_port needs the head word early
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               arm,
  input  logic               trigger,
  input  logic               sample_valid,
  input  trace_pkg::sample_t sample,
  input  trace_pkg::count_t  sample_count,
  input  logic [31:0]        threshold,      // almost-full level in words
  input  logic               req,
  output logic               ack,
  output trace_pkg::sample_t rd_data,
  output logic               busy,
  output logic               done,
  output logic               truncated,
  output logic               fifo_empty,
  output logic               almost_full
);

  import trace_pkg::*;

  logic    fifo_wen;
  sample_t fifo_wdata;
  logic    fifo_full;
  logic    fifo_ren;
  sample_t fifo_rdata;

  // capture side
  capture_ctrl capture_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .arm          (arm),
    .trigger      (trigger),
    .sample_valid (sample_valid),
    .sample       (sample),
    .sample_count (sample_count),
    .fifo_full    (fifo_full),
    .fifo_wen     (fifo_wen),
    .fifo_wdata   (fifo_wdata),
    .busy         (busy),
    .done         (done),
    .truncated    (truncated)
  );

  // trace buffer
  fifo_sync #(
    .pDATA_WIDTH  (SAMPLE_W),
    .pDEPTH       (pDEPTH),
    .pFALLTHROUGH (pFALLTHROUGH)
  ) fifo_sync_inst (
    .clk                  (clk),
    .rst_n                (rst_n),
    .full_threshold_value (threshold),
    .wen                  (fifo_wen),
    .wdata                (fifo_wdata),
    .full                 (fifo_full),
    .overflow             (),             // drops already show as truncated
    .full_threshold       (almost_full),
    .ren                  (fifo_ren),
    .rdata                (fifo_rdata),
    .empty                (fifo_empty),
    .almost_empty         (),
    .underflow            ()              // readout never pops when empty
  );

  // host side
  readout_port readout_port_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .fifo_empty (fifo_empty),
    .fifo_rdata (fifo_rdata),
    .fifo_ren   (fifo_ren),
    .ack        (ack),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

// ==== trace_pkg.sv ====
`default_nettype none

package trace_pkg;

  // adc sample word
  localparam int SAMPLE_W = 12;

  typedef logic [SAMPLE_W-1:0] sample_t;

  // requested number of samples per capture
  localparam int COUNT_W = 16;

  typedef logic [COUNT_W-1:0] count_t;

  // capture sequencer states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,   // waiting for arm
    ARMED     = 2'd1,   // waiting for trigger
    CAPTURING = 2'd2    // writing samples into the fifo
  } cap_state_t;

endpackage

`default_nettype wire
